// File: src/bubblePkg.sv
`default_nettype none

package bubblePkg;

    // Encoded as {pageSelect, coilEnable, positionLatch}
    typedef enum logic [2:0] {
        BootloaderAccess = 3'b000,  // B
        InitialStandby   = 3'b010,  // A
        NormalAccess     = 3'b100,  // D
        PageLatch        = 3'b101,  // E
        NormalStandby    = 3'b110   // C
    } accessState;

    typedef enum logic [1:0] {
        Idle             = 2'b00,  // Park address before word 0
        AddressIncrement = 2'b01,
        DataOut          = 2'b10
    } seqCommand;

    // Buffer RAM geometry
    localparam int AddressWidth = 11;
    localparam int BufferDepth  = 2048;

    localparam int PositionWidth = 12;
    localparam int TickWidth     = 14;

    // Counts of the real bubble module
    localparam int DefaultPositionCount = 2053;  // Positions 0 to 2052
    localparam int DefaultPageStart     = 201;
    localparam int DefaultPageWords     = 512;
    localparam int DefaultBootStart     = 5285;
    localparam int DefaultBootWords     = 1920;
    localparam int DefaultBootTrailer   = 12;

endpackage

`default_nettype wire

// File: src/accessStateMachine.sv
`default_nettype none

module accessStateMachine
(
    input  logic bubble_buffer_write_clock,
    input  logic reset,
    input  logic pageSelect,
    input  logic coilEnable,      // Active low
    input  logic positionLatch,
    output logic loadBootloader,  // Active low
    output logic loadPage         // Active low
);
    import bubblePkg::*;

    accessState state;
    accessState nextState;
    logic [2:0] accessInputs;

    assign accessInputs = {pageSelect, coilEnable, positionLatch};

    always_comb
    begin
        nextState = state;  // Invalid combinations hold
        case (accessInputs)
            BootloaderAccess:
            begin
                if (state != NormalAccess && state != PageLatch)  // D or E to B is a glitch
                begin
                    nextState = BootloaderAccess;
                end
            end
            InitialStandby:
            begin
                if (state != PageLatch)  // E to A is a glitch
                begin
                    nextState = InitialStandby;
                end
            end
            NormalAccess:
            begin
                nextState = NormalAccess;
            end
            PageLatch:
            begin
                if (state == NormalAccess)  // Only D to E
                begin
                    nextState = PageLatch;
                end
            end
            NormalStandby:
            begin
                if (state != PageLatch)  // E to C is a glitch
                begin
                    nextState = NormalStandby;
                end
            end
            default:
            begin
                nextState = state;
            end
        endcase
    end

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset)
        begin
            state <= InitialStandby;
        end
        else
        begin
            state <= nextState;
        end
    end

    assign loadBootloader = (state != BootloaderAccess);
    assign loadPage       = (state != PageLatch);

endmodule

`default_nettype wire

// File: src/positionCounter.sv
`default_nettype none

module positionCounter
#(
    parameter int PositionCount = bubblePkg::DefaultPositionCount
)
(
    input  logic                               bubble_buffer_write_clock,
    input  logic                               reset,
    input  logic                               positionChange,
    input  logic                               positionReset,  // Sync to bootloader start
    output logic [bubblePkg::PositionWidth-1:0] bubblePosition
);
    import bubblePkg::*;

    localparam logic [PositionWidth-1:0] LastPosition = PositionWidth'(PositionCount - 1);

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset || positionReset)
        begin
            bubblePosition <= '0;
        end
        else if (positionChange)
        begin
            if (bubblePosition == LastPosition)  // Wrap around the loop
            begin
                bubblePosition <= '0;
            end
            else
            begin
                bubblePosition <= bubblePosition + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/bubbleBuffer.sv
`default_nettype none

module bubbleBuffer
(
    input  logic                              bubble_buffer_write_clock,
    input  logic [bubblePkg::AddressWidth-1:0] writeAddress,
    input  logic [1:0]                        writeData,
    input  logic                              writeEnable,  // Active low
    input  logic [bubblePkg::AddressWidth-1:0] readAddress,
    output logic [1:0]                        readData      // {odd, even}
);
    import bubblePkg::*;

    logic [1:0] memory [BufferDepth];

    // Loader side
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (!writeEnable)
        begin
            memory[writeAddress] <= writeData;
        end
    end

    // Registered read for block RAM inference
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        readData <= memory[readAddress];
    end

endmodule

`default_nettype wire

// File: src/outputSequencer.sv
`default_nettype none

module outputSequencer
#(
    parameter int PageStart   = bubblePkg::DefaultPageStart,
    parameter int PageWords   = bubblePkg::DefaultPageWords,
    parameter int BootStart   = bubblePkg::DefaultBootStart,
    parameter int BootWords   = bubblePkg::DefaultBootWords,
    parameter int BootTrailer = bubblePkg::DefaultBootTrailer
)
(
    input  logic                              bubble_buffer_write_clock,
    input  logic                              reset,
    input  logic                              dataOutTick,
    input  logic                              bubbleModuleEnable,  // Active low
    input  logic                              loadBootloader,      // Active low
    input  logic                              loadPage,            // Active low
    input  logic [1:0]                        readData,
    output logic [bubblePkg::AddressWidth-1:0] readAddress,
    output logic                              positionReset,
    output logic                              bubbleOutOdd,
    output logic                              bubbleOutEven
);
    import bubblePkg::*;

    localparam logic [TickWidth-1:0] PageFirst = TickWidth'(PageStart);
    localparam logic [TickWidth-1:0] PageLast  = TickWidth'(PageStart + 2 * PageWords - 1);
    localparam logic [TickWidth-1:0] MarkFirst = TickWidth'(BootStart - 4);
    localparam logic [TickWidth-1:0] MarkLast  = TickWidth'(BootStart - 3);
    localparam logic [TickWidth-1:0] GapFirst  = TickWidth'(BootStart - 2);
    localparam logic [TickWidth-1:0] BootFirst = TickWidth'(BootStart);
    localparam logic [TickWidth-1:0] BootLast  = TickWidth'(BootStart + 2 * BootWords - 1);
    localparam logic [TickWidth-1:0] TrailLast =
        TickWidth'(BootStart + 2 * BootWords + BootTrailer - 1);

    logic                 countEnable;
    logic                 pageMode;
    logic                 bootMode;
    logic [TickWidth-1:0] tickCount;
    logic [TickWidth-1:0] nextTick;
    logic [TickWidth-1:0] windowFirst;
    logic [TickWidth-1:0] windowLast;
    logic [TickWidth-1:0] windowOffset;
    seqCommand            command;

    assign countEnable = !(loadBootloader && loadPage);
    assign bootMode    = !loadBootloader && loadPage;
    assign pageMode    = !loadPage && loadBootloader;
    assign nextTick    = tickCount + 1'b1;

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset || !countEnable)
        begin
            tickCount <= '0;
        end
        else if (dataOutTick && tickCount != '1)  // Saturate at the top
        begin
            tickCount <= nextTick;
        end
    end

    // Command decode looks at the count this tick is about to produce
    always_comb
    begin
        windowFirst  = pageMode ? PageFirst : BootFirst;
        windowLast   = pageMode ? PageLast : BootLast;
        windowOffset = nextTick - windowFirst;
        if (nextTick >= windowFirst && nextTick <= windowLast)
        begin
            command = windowOffset[0] ? DataOut : AddressIncrement;
        end
        else
        begin
            command = Idle;
        end
    end

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset || !countEnable)
        begin
            readAddress <= '1;  // Next increment lands on word 0
        end
        else if (dataOutTick)
        begin
            case (command)
                AddressIncrement: readAddress <= readAddress + 1'b1;
                DataOut:          readAddress <= readAddress;  // Second half of the word
                default:          readAddress <= '1;
            endcase
        end
    end

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (reset)
        begin
            positionReset <= 1'b0;
        end
        else
        begin
            positionReset <= bootMode && tickCount >= MarkLast && tickCount <= GapFirst;
        end
    end

    always_comb
    begin
        bubbleOutOdd  = 1'b1;
        bubbleOutEven = 1'b1;
        if (bubbleModuleEnable)  // Module deselected
        begin
            bubbleOutOdd  = 1'b0;
            bubbleOutEven = 1'b0;
        end
        else if (bootMode)
        begin
            if (tickCount >= MarkFirst && tickCount <= MarkLast)  // Start pattern
            begin
                bubbleOutEven = 1'b0;
            end
            else if (tickCount >= GapFirst && tickCount < BootFirst)
            begin
                bubbleOutOdd  = 1'b0;
                bubbleOutEven = 1'b0;
            end
            else if (tickCount >= BootFirst && tickCount <= BootLast)
            begin
                bubbleOutOdd  = ~readData[1];
                bubbleOutEven = ~readData[0];
            end
            else if (tickCount > BootLast && tickCount <= TrailLast)  // Zero trailer
            begin
                bubbleOutOdd  = 1'b0;
                bubbleOutEven = 1'b0;
            end
        end
        else if (pageMode && tickCount >= PageFirst && tickCount <= PageLast)
        begin
            bubbleOutOdd  = ~readData[1];
            bubbleOutEven = ~readData[0];
        end
    end

endmodule

`default_nettype wire

// File: src/bubbleInterface.sv
`default_nettype none

module bubbleInterface
#(
    parameter int PositionCount = bubblePkg::DefaultPositionCount,
    parameter int PageStart     = bubblePkg::DefaultPageStart,
    parameter int PageWords     = bubblePkg::DefaultPageWords,
    parameter int BootStart     = bubblePkg::DefaultBootStart,
    parameter int BootWords     = bubblePkg::DefaultBootWords,
    parameter int BootTrailer   = bubblePkg::DefaultBootTrailer
)
(
    input  logic                               bubble_buffer_write_clock,
    input  logic                               reset,
    input  logic                               bubbleModuleEnable,  // Active low
    input  logic                               positionChange,
    input  logic                               positionLatch,
    input  logic                               pageSelect,
    input  logic                               coilEnable,          // Active low
    input  logic                               dataOutTick,
    input  logic [bubblePkg::AddressWidth-1:0]  writeAddress,
    input  logic [1:0]                         writeData,
    input  logic                               writeEnable,         // Active low
    output logic                               convert,
    output logic [bubblePkg::PositionWidth-1:0] bubblePosition,
    output logic                               loadPage,            // Active low
    output logic                               loadBootloader,      // Active low
    output logic                               bubbleOutOdd,
    output logic                               bubbleOutEven
);
    import bubblePkg::*;

    logic [AddressWidth-1:0] readAddress;
    logic [1:0]              readData;
    logic                    positionReset;

    assign convert = positionLatch;  // Only meaningful outside bootloader access

    accessStateMachine u_accessStateMachine
    (
        .bubble_buffer_write_clock(bubble_buffer_write_clock),
        .reset(reset),
        .pageSelect(pageSelect),
        .coilEnable(coilEnable),
        .positionLatch(positionLatch),
        .loadBootloader(loadBootloader),
        .loadPage(loadPage)
    );

    positionCounter #(.PositionCount(PositionCount)) u_positionCounter
    (
        .bubble_buffer_write_clock(bubble_buffer_write_clock),
        .reset(reset),
        .positionChange(positionChange),
        .positionReset(positionReset),
        .bubblePosition(bubblePosition)
    );

    bubbleBuffer u_bubbleBuffer
    (
        .bubble_buffer_write_clock(bubble_buffer_write_clock),
        .writeAddress(writeAddress),
        .writeData(writeData),
        .writeEnable(writeEnable),
        .readAddress(readAddress),
        .readData(readData)
    );

    outputSequencer
    #(
        .PageStart(PageStart),
        .PageWords(PageWords),
        .BootStart(BootStart),
        .BootWords(BootWords),
        .BootTrailer(BootTrailer)
    ) u_outputSequencer
    (
        .bubble_buffer_write_clock(bubble_buffer_write_clock),
        .reset(reset),
        .dataOutTick(dataOutTick),
        .bubbleModuleEnable(bubbleModuleEnable),
        .loadBootloader(loadBootloader),
        .loadPage(loadPage),
        .readData(readData),
        .readAddress(readAddress),
        .positionReset(positionReset),
        .bubbleOutOdd(bubbleOutOdd),
        .bubbleOutEven(bubbleOutEven)
    );

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`default_nettype none

module clockGen
(
    output logic bubble_buffer_write_clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        bubble_buffer_write_clock = 1'b0;
        forever #4 bubble_buffer_write_clock = ~bubble_buffer_write_clock;  // 8 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge bubble_buffer_write_clock);
        #1 reset = 1'b0;  // Released just after the tenth edge
    end

endmodule

`default_nettype wire

// File: tests/bubbleInterface_assert.sv
`default_nettype none

module bubbleInterfaceAssert
#(
    parameter int PositionCount = bubblePkg::DefaultPositionCount
)
(
    input logic                               bubble_buffer_write_clock,
    input logic                               reset,
    input logic                               pageSelect,
    input logic                               coilEnable,
    input logic                               positionLatch,
    input logic                               loadBootloader,
    input logic                               loadPage,
    input logic                               bubbleModuleEnable,
    input logic                               bubbleOutOdd,
    input logic                               bubbleOutEven,
    input logic                               positionChange,
    input logic                               positionReset,
    input logic [bubblePkg::PositionWidth-1:0] bubblePosition,
    input logic [2:0]                         stateValue
);
    timeunit 1ns;
    timeprecision 100ps;
    import bubblePkg::*;

    localparam int LastPosition = PositionCount - 1;

    logic [2:0] accessInputs;
    int         assertFailures = 0;  // Read by the testbench top

    assign accessInputs = {pageSelect, coilEnable, positionLatch};

    resetState: assert property (@(posedge bubble_buffer_write_clock)
        $fell(reset) |-> stateValue == InitialStandby && bubblePosition == 0)
    else
    begin
        $error("State or position not cleared by reset");
        assertFailures++;
    end

    bootEntry: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        accessInputs == 3'b000 && !(stateValue inside {NormalAccess, PageLatch})
        |=> stateValue == BootloaderAccess && !loadBootloader)
    else
    begin
        $error("Bootloader access not entered one cycle after the combination");
        assertFailures++;
    end

    normalEntry: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        accessInputs == 3'b100 |=> stateValue == NormalAccess && loadBootloader && loadPage)
    else
    begin
        $error("Normal access not entered one cycle after the combination");
        assertFailures++;
    end

    latchGlitchHold: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        stateValue == PageLatch && accessInputs inside {3'b010, 3'b110}
        |=> stateValue == PageLatch)
    else
    begin
        $error("Page latch state left on a glitch");
        assertFailures++;
    end

    bootGlitchHold: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        stateValue inside {NormalAccess, PageLatch} && accessInputs == 3'b000
        |=> $stable(stateValue))
    else
    begin
        $error("Normal access state left on a bootloader glitch");
        assertFailures++;
    end

    pageLatchTiming: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        stateValue == NormalAccess && accessInputs == 3'b101 |=> !loadPage)
    else
    begin
        $error("loadPage not low one cycle after the page latch");
        assertFailures++;
    end

    positionWrap: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        positionChange && !positionReset && bubblePosition == LastPosition
        |=> bubblePosition == 0)
    else
    begin
        $error("Position counter did not wrap to zero");
        assertFailures++;
    end

    disabledQuiet: assert property (@(posedge bubble_buffer_write_clock) disable iff (reset)
        bubbleModuleEnable |-> !bubbleOutOdd && !bubbleOutEven)
    else
    begin
        $error("Outputs driven while the module is disabled");
        assertFailures++;
    end

endmodule

bind bubbleInterface bubbleInterfaceAssert #(.PositionCount(PositionCount)) u_bubbleInterfaceAssert
(
    .bubble_buffer_write_clock(bubble_buffer_write_clock),
    .reset(reset),
    .pageSelect(pageSelect),
    .coilEnable(coilEnable),
    .positionLatch(positionLatch),
    .loadBootloader(loadBootloader),
    .loadPage(loadPage),
    .bubbleModuleEnable(bubbleModuleEnable),
    .bubbleOutOdd(bubbleOutOdd),
    .bubbleOutEven(bubbleOutEven),
    .positionChange(positionChange),
    .positionReset(positionReset),
    .bubblePosition(bubblePosition),
    .stateValue(u_accessStateMachine.state)
);

`default_nettype wire

// File: tests/bubbleInterfaceTb.sv
`default_nettype none

module bubbleInterfaceTb;
    timeunit 1ns;
    timeprecision 100ps;
    import bubblePkg::*;

    localparam int PositionCount = 10;
    localparam int PageStart     = 9;
    localparam int PageWords     = 8;
    localparam int BootStart     = 12;
    localparam int BootWords     = 8;
    localparam int BootTrailer   = 4;
    localparam int PageMode      = 1;
    localparam int BootMode      = 2;

    // Access combinations as {pageSelect, coilEnable, positionLatch}
    localparam logic [2:0] ComboA = 3'b010;  // Initial standby
    localparam logic [2:0] ComboB = 3'b000;  // Bootloader access
    localparam logic [2:0] ComboC = 3'b110;  // Normal standby
    localparam logic [2:0] ComboD = 3'b100;  // Normal access
    localparam logic [2:0] ComboE = 3'b101;  // Page latch

    logic                     bubble_buffer_write_clock;
    logic                     reset;
    logic                     bubbleModuleEnable;
    logic                     positionChange;
    logic                     positionLatch;
    logic                     pageSelect;
    logic                     coilEnable;
    logic                     dataOutTick;
    logic [AddressWidth-1:0]  writeAddress;
    logic [1:0]               writeData;
    logic                     writeEnable;
    logic                     convert;
    logic [PositionWidth-1:0] bubblePosition;
    logic                     loadPage;
    logic                     loadBootloader;
    logic                     bubbleOutOdd;
    logic                     bubbleOutEven;
    logic [1:0]               modelMemory [16];  // {odd, even} per word
    int                       errorCount = 0;
    int                       checkCount = 0;
    int                       expectedPosition = 0;
    int                       assertFailures;

    clockGen u_clockGen
    (
        .bubble_buffer_write_clock(bubble_buffer_write_clock),
        .reset(reset)
    );

    bubbleInterface
    #(
        .PositionCount(PositionCount),
        .PageStart(PageStart),
        .PageWords(PageWords),
        .BootStart(BootStart),
        .BootWords(BootWords),
        .BootTrailer(BootTrailer)
    ) u_bubbleInterface
    (
        .bubble_buffer_write_clock(bubble_buffer_write_clock),
        .reset(reset),
        .bubbleModuleEnable(bubbleModuleEnable),
        .positionChange(positionChange),
        .positionLatch(positionLatch),
        .pageSelect(pageSelect),
        .coilEnable(coilEnable),
        .dataOutTick(dataOutTick),
        .writeAddress(writeAddress),
        .writeData(writeData),
        .writeEnable(writeEnable),
        .convert(convert),
        .bubblePosition(bubblePosition),
        .loadPage(loadPage),
        .loadBootloader(loadBootloader),
        .bubbleOutOdd(bubbleOutOdd),
        .bubbleOutEven(bubbleOutEven)
    );

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("ERROR %s: expected %0h, actual %0h", testName, expected, actual);
        end
    endtask

    task automatic waitForReset();
        int cycles = 0;
        do
        begin
            @(posedge bubble_buffer_write_clock);
            cycles++;
        end
        while (reset !== 1'b0 && cycles < 50);
        if (reset !== 1'b0)
        begin
            errorCount++;
            $display("Reset was still asserted after 50 clock cycles");
        end
        #1;
    endtask

    // Drives one access combination and waits for the load levels to settle
    task automatic driveAccess(input string stepName, input logic [2:0] combination,
                               input logic expectBoot, input logic expectPage);
        int cycles = 0;
        {pageSelect, coilEnable, positionLatch} = combination;
        do
        begin
            @(posedge bubble_buffer_write_clock);
            #1;
            cycles++;
        end
        while ((loadBootloader !== expectBoot || loadPage !== expectPage) && cycles < 4);
        checkValue({stepName, " loadBootloader"}, expectBoot, loadBootloader);
        checkValue({stepName, " loadPage"}, expectPage, loadPage);
    endtask

    task automatic writeWords(input int count);
        for (int i = 0; i < count; i++)
        begin
            modelMemory[i] = 2'($urandom);
            writeAddress   = AddressWidth'(i);
            writeData      = modelMemory[i];
            writeEnable    = 1'b0;  // Active low
            @(posedge bubble_buffer_write_clock);
            #1;
        end
        writeEnable = 1'b1;
    endtask

    task automatic pulsePosition(input int count);
        for (int i = 0; i < count; i++)
        begin
            positionChange = 1'b1;
            @(posedge bubble_buffer_write_clock);
            #1;
            positionChange   = 1'b0;
            expectedPosition = (expectedPosition + 1) % PositionCount;
            checkValue($sformatf("position pulse %0d", i + 1), expectedPosition, bubblePosition);
        end
    endtask

    // One tick, then wait until just before the next one may come
    task automatic issueTick();
        dataOutTick = 1'b1;
        @(posedge bubble_buffer_write_clock);
        #1;
        dataOutTick = 1'b0;
        repeat (3) @(posedge bubble_buffer_write_clock);
        #1;
    endtask

    function automatic logic [1:0] expectedOutputs(input int mode, input int tick,
                                                   input logic disabled);
        if (disabled)
            return 2'b00;
        if (mode == PageMode && tick >= PageStart && tick < PageStart + 2 * PageWords)
            return ~modelMemory[(tick - PageStart) / 2];
        if (mode == BootMode)
        begin
            if (tick == BootStart - 4 || tick == BootStart - 3)
                return 2'b10;  // Odd high, even low
            if (tick == BootStart - 2 || tick == BootStart - 1)
                return 2'b00;
            if (tick >= BootStart && tick < BootStart + 2 * BootWords)
                return ~modelMemory[(tick - BootStart) / 2];
            if (tick >= BootStart + 2 * BootWords &&
                tick < BootStart + 2 * BootWords + BootTrailer)
                return 2'b00;  // Zero trailer
        end
        return 2'b11;
    endfunction

    task automatic runTicks(input string testName, input int mode, input int count);
        for (int k = 0; k <= count; k++)
        begin
            if (k > 0)
                issueTick();
            checkValue($sformatf("%s tick %0d", testName, k),
                       expectedOutputs(mode, k, bubbleModuleEnable),
                       {bubbleOutOdd, bubbleOutEven});
            if (mode == BootMode && k == BootStart - 1 && !bubbleModuleEnable)
            begin
                expectedPosition = 0;  // Aligned by the start pattern
                checkValue("position after start pattern", expectedPosition, bubblePosition);
            end
        end
    endtask

    initial
    begin
        bubbleModuleEnable = 1'b0;
        positionChange     = 1'b0;
        dataOutTick        = 1'b0;
        writeAddress       = '0;
        writeData          = 2'b00;
        writeEnable        = 1'b1;
        {pageSelect, coilEnable, positionLatch} = ComboA;
        void'($urandom(32'h78be));
        waitForReset();

        checkValue("reset loadPage", 1, loadPage);
        checkValue("reset loadBootloader", 1, loadBootloader);
        checkValue("reset outputs", 2'b11, {bubbleOutOdd, bubbleOutEven});
        checkValue("reset position", 0, bubblePosition);

        pulsePosition(13);  // Wraps once at the small count
        positionLatch = 1'b1;
        @(posedge bubble_buffer_write_clock);
        #1;
        checkValue("convert high", 1, convert);
        positionLatch = 1'b0;
        @(posedge bubble_buffer_write_clock);
        #1;
        checkValue("convert low", 0, convert);

        driveAccess("access A", ComboA, 1'b1, 1'b1);
        driveAccess("access B", ComboB, 1'b0, 1'b1);
        driveAccess("access D", ComboD, 1'b1, 1'b1);
        driveAccess("access C", ComboC, 1'b1, 1'b1);
        driveAccess("access D again", ComboD, 1'b1, 1'b1);
        driveAccess("access E", ComboE, 1'b1, 1'b0);
        driveAccess("glitch E to C", ComboC, 1'b1, 1'b0);
        driveAccess("glitch E to A", ComboA, 1'b1, 1'b0);
        driveAccess("access E to D", ComboD, 1'b1, 1'b1);
        driveAccess("glitch D to B", ComboB, 1'b1, 1'b1);
        driveAccess("access C after glitch", ComboC, 1'b1, 1'b1);
        driveAccess("access A at end", ComboA, 1'b1, 1'b1);

        writeWords(16);
        driveAccess("page enter D", ComboD, 1'b1, 1'b1);
        driveAccess("page enter E", ComboE, 1'b1, 1'b0);
        runTicks("page", PageMode, PageStart + 2 * PageWords + 2);
        driveAccess("page exit D", ComboD, 1'b1, 1'b1);
        driveAccess("page exit C", ComboC, 1'b1, 1'b1);
        checkValue("idle outputs", 2'b11, {bubbleOutOdd, bubbleOutEven});

        writeWords(16);
        driveAccess("boot enter B", ComboB, 1'b0, 1'b1);
        runTicks("boot", BootMode, BootStart + 2 * BootWords + BootTrailer + 2);
        driveAccess("boot exit A", ComboA, 1'b1, 1'b1);

        bubbleModuleEnable = 1'b1;  // Module deselected
        @(posedge bubble_buffer_write_clock);
        #1;
        checkValue("disabled idle", 2'b00, {bubbleOutOdd, bubbleOutEven});
        driveAccess("disabled page D", ComboD, 1'b1, 1'b1);
        driveAccess("disabled page E", ComboE, 1'b1, 1'b0);
        runTicks("disabled page", PageMode, PageStart + 2);
        driveAccess("disabled exit D", ComboD, 1'b1, 1'b1);
        driveAccess("disabled exit C", ComboC, 1'b1, 1'b1);
        driveAccess("disabled boot B", ComboB, 1'b0, 1'b1);
        runTicks("disabled boot", BootMode, BootStart + 2);
        driveAccess("disabled exit A", ComboA, 1'b1, 1'b1);
        bubbleModuleEnable = 1'b0;
        repeat (2) @(posedge bubble_buffer_write_clock);

        assertFailures = u_bubbleInterface.u_bubbleInterfaceAssert.assertFailures;
        $display("Checks run: %0d, value errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFailures);
        if (errorCount == 0 && assertFailures == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bubbleInterface.f
src/bubblePkg.sv
src/accessStateMachine.sv
src/positionCounter.sv
src/bubbleBuffer.sv
src/outputSequencer.sv
src/bubbleInterface.sv
tests/clockGen.sv
tests/bubbleInterface_assert.sv
tests/bubbleInterfaceTb.sv
